// ==== source/axi3_consts.svh ====
// Width and depth constants shared by the package, the RTL and the testbench; include as needed
`ifndef AXI3_CONSTS_SVH
`define AXI3_CONSTS_SVH

// Transaction id and byte address widths
`define AXI3_ID_WID 4
`define AXI3_ADDR_WID 16

// Bytes per data beat
`define AXI3_DATA_BYTES 4
`define AXI3_DATA_WID (`AXI3_DATA_BYTES * 8)

// Memory depth in words
`define AXI3_MEM_WORDS 256

`endif

// ==== source/axi3_pkg.sv ====
// AXI3 burst, size and response encodings plus the channel payload structs used by the core
`default_nettype none
`include "axi3_consts.svh"

package axi3_pkg;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'd0,
        BURST_INCR  = 2'd1,
        BURST_WRAP  = 2'd2
    } axburst_t;

    // Bytes per beat as a power of two
    typedef enum logic [2:0] {
        SIZE_1B   = 3'd0,
        SIZE_2B   = 3'd1,
        SIZE_4B   = 3'd2,
        SIZE_8B   = 3'd3,
        SIZE_16B  = 3'd4,
        SIZE_32B  = 3'd5,
        SIZE_64B  = 3'd6,
        SIZE_128B = 3'd7
    } axsize_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_EXOKAY = 2'd1,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } resp_t;

    // Shared by AW and AR
    typedef struct packed {
        logic [`AXI3_ID_WID-1:0]   id;
        logic [`AXI3_ADDR_WID-1:0] addr;
        logic [3:0]                len;
        axsize_t                   size;
        axburst_t                  burst;
    } ax_payload_t;

    typedef struct packed {
        logic [`AXI3_ID_WID-1:0]     id;
        logic [`AXI3_DATA_WID-1:0]   data;
        logic [`AXI3_DATA_BYTES-1:0] strb;
        logic                        last;
    } w_payload_t;

    typedef struct packed {
        logic [`AXI3_ID_WID-1:0] id;
        resp_t                   resp;
    } b_payload_t;

    typedef struct packed {
        logic [`AXI3_ID_WID-1:0]   id;
        logic [`AXI3_DATA_WID-1:0] data;
        resp_t                     resp;
        logic                      last;
    } r_payload_t;

endpackage

`default_nettype wire

// ==== source/axi3_bus_adapter.sv ====
// Terminates the AXI3 subordinate ports into payload buses, each through a one-entry register slice
`timescale 1ns/1ns
`default_nettype none
`include "axi3_consts.svh"

module axi3_bus_adapter (
    input  logic                          clk,
    input  logic                          reset,
    // AXI3 subordinate side
    input  logic                          awvalid,
    input  logic [`AXI3_ID_WID-1:0]       awid,
    input  logic [`AXI3_ADDR_WID-1:0]     awaddr,
    input  logic [3:0]                    awlen,
    input  logic [2:0]                    awsize,
    input  logic [1:0]                    awburst,
    output logic                          awready,
    input  logic                          wvalid,
    input  logic [`AXI3_ID_WID-1:0]       wid,
    input  logic [`AXI3_DATA_WID-1:0]     wdata,
    input  logic [`AXI3_DATA_BYTES-1:0]   wstrb,
    input  logic                          wlast,
    output logic                          wready,
    output logic                          bvalid,
    output logic [`AXI3_ID_WID-1:0]       bid,
    output logic [1:0]                    bresp,
    input  logic                          bready,
    input  logic                          arvalid,
    input  logic [`AXI3_ID_WID-1:0]       arid,
    input  logic [`AXI3_ADDR_WID-1:0]     araddr,
    input  logic [3:0]                    arlen,
    input  logic [2:0]                    arsize,
    input  logic [1:0]                    arburst,
    output logic                          arready,
    output logic                          rvalid,
    output logic [`AXI3_ID_WID-1:0]       rid,
    output logic [`AXI3_DATA_WID-1:0]     rdata,
    output logic [1:0]                    rresp,
    output logic                          rlast,
    input  logic                          rready,
    // Core side
    output logic                          aw_valid,
    output axi3_pkg::ax_payload_t         aw_payload,
    input  logic                          aw_ready,
    output logic                          w_valid,
    output axi3_pkg::w_payload_t          w_payload,
    input  logic                          w_ready,
    output logic                          ar_valid,
    output axi3_pkg::ax_payload_t         ar_payload,
    input  logic                          ar_ready,
    input  logic                          b_valid,
    input  axi3_pkg::b_payload_t          b_payload,
    output logic                          b_ready,
    input  logic                          r_valid,
    input  axi3_pkg::r_payload_t          r_payload,
    output logic                          r_ready
);
    import axi3_pkg::*;

    // Slot order is aw, w, ar, b, r; the widest payload sets the slot width
    localparam int NCH = 5;
    localparam int SW = $bits(w_payload_t);

    ax_payload_t    aw_in;
    ax_payload_t    ar_in;
    w_payload_t     w_in;
    b_payload_t     b_out;
    r_payload_t     r_out;
    logic           live;
    logic [NCH-1:0] in_valid;
    logic [NCH-1:0] in_ready;
    logic [NCH-1:0] out_valid;
    logic [NCH-1:0] out_ready;
    logic [SW-1:0]  in_data [NCH];
    logic [SW-1:0]  out_data [NCH];

    assign aw_in.id    = awid;
    assign aw_in.addr  = awaddr;
    assign aw_in.len   = awlen;
    assign aw_in.size  = axsize_t'(awsize);
    assign aw_in.burst = axburst_t'(awburst);

    assign w_in.id   = wid;
    assign w_in.data = wdata;
    assign w_in.strb = wstrb;
    assign w_in.last = wlast;

    assign ar_in.id    = arid;
    assign ar_in.addr  = araddr;
    assign ar_in.len   = arlen;
    assign ar_in.size  = axsize_t'(arsize);
    assign ar_in.burst = axburst_t'(arburst);

    assign in_valid = {r_valid, b_valid, arvalid, wvalid, awvalid};
    assign out_ready = {rready, bready, ar_ready, w_ready, aw_ready};
    assign {r_ready, b_ready, arready, wready, awready} = in_ready;
    assign {rvalid, bvalid, ar_valid, w_valid, aw_valid} = out_valid;

    assign in_data[0] = SW'(aw_in);
    assign in_data[1] = SW'(w_in);
    assign in_data[2] = SW'(ar_in);
    assign in_data[3] = SW'(b_payload);
    assign in_data[4] = SW'(r_payload);

    assign aw_payload = ax_payload_t'(out_data[0][$bits(ax_payload_t)-1:0]);
    assign w_payload  = w_payload_t'(out_data[1]);
    assign ar_payload = ax_payload_t'(out_data[2][$bits(ax_payload_t)-1:0]);
    assign b_out      = b_payload_t'(out_data[3][$bits(b_payload_t)-1:0]);
    assign r_out      = r_payload_t'(out_data[4][$bits(r_payload_t)-1:0]);

    assign bid   = b_out.id;
    assign bresp = b_out.resp;
    assign rid   = r_out.id;
    assign rdata = r_out.data;
    assign rresp = r_out.resp;
    assign rlast = r_out.last;

    // Keeps every ready low for the first cycle out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    for (genvar i = 0; i < NCH; i++) begin : g_slice
        logic          full;
        logic [SW-1:0] hold;

        // Refill in the same cycle the held entry drains
        assign in_ready[i] = live && (!full || out_ready[i]);
        assign out_valid[i] = full;
        assign out_data[i] = hold;

        always_ff @(posedge clk) begin
            if (reset) begin
                full <= 1'b0;
            end else if (in_ready[i]) begin
                full <= in_valid[i];
            end
        end

        always_ff @(posedge clk) begin
            if (in_valid[i] && in_ready[i]) begin
                hold <= in_data[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/burst_decoder.sv ====
// Takes AW, W and AR payloads one burst at a time and issues one memory beat per cycle
`timescale 1ns/1ns
`default_nettype none
`include "axi3_consts.svh"

module burst_decoder (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          aw_valid,
    input  axi3_pkg::ax_payload_t         aw_payload,
    output logic                          aw_ready,
    input  logic                          w_valid,
    input  axi3_pkg::w_payload_t          w_payload,
    output logic                          w_ready,
    input  logic                          ar_valid,
    input  axi3_pkg::ax_payload_t         ar_payload,
    output logic                          ar_ready,
    input  logic                          stall,
    output logic                          mem_en,
    output logic                          mem_write,
    output logic [`AXI3_ADDR_WID-1:0]     mem_addr,
    output logic [`AXI3_DATA_WID-1:0]     mem_wdata,
    output logic [`AXI3_DATA_BYTES-1:0]   mem_strb,
    output logic                          beat_is_read,
    output logic [`AXI3_ID_WID-1:0]       beat_id,
    output logic                          beat_last
);
    import axi3_pkg::*;

    localparam int AW = `AXI3_ADDR_WID;
    localparam int OFF_WID = $clog2(`AXI3_DATA_BYTES);

    logic                    active;
    logic                    last_read;
    logic                    cur_read;
    logic [`AXI3_ID_WID-1:0] cur_id;
    logic [AW-1:0]           cur_addr;
    logic [3:0]              cur_len;
    logic [3:0]              beats_left;
    logic [2:0]              cur_shift;
    axburst_t                cur_burst;
    logic                    pick_read;
    logic                    pick_write;
    logic                    beat_go;
    ax_payload_t             sel;
    logic [2:0]              load_shift;
    logic [AW-1:0]           step;
    logic [AW-1:0]           wrap_mask;
    logic [AW-1:0]           next_addr;

    // Alternate when both kinds wait
    assign pick_read  = !active && ar_valid && (!aw_valid || !last_read);
    assign pick_write = !active && aw_valid && !pick_read;
    assign ar_ready = pick_read;
    assign aw_ready = pick_write;
    assign sel = pick_read ? ar_payload : aw_payload;

    // Sizes wider than the bus run at full width
    assign load_shift = (sel.size > 3'(OFF_WID)) ? 3'(OFF_WID) : sel.size;

    assign w_ready = active && !cur_read && !stall;
    assign beat_go = active && !stall && (cur_read || w_valid);

    assign mem_en       = beat_go;
    assign mem_write    = !cur_read;
    assign mem_addr     = cur_addr;
    assign mem_wdata    = w_payload.data;
    assign mem_strb     = w_payload.strb;
    assign beat_is_read = cur_read;
    assign beat_id      = cur_id;
    assign beat_last    = (beats_left == 4'd0);

    assign step = AW'(1) << cur_shift;
    // Wrap block is beat count times beat size
    assign wrap_mask = ((AW'(cur_len) + AW'(1)) << cur_shift) - AW'(1);

    always_comb begin
        case (cur_burst)
            BURST_FIXED: next_addr = cur_addr;
            BURST_WRAP:  next_addr = (cur_addr & ~wrap_mask) | ((cur_addr + step) & wrap_mask);
            default:     next_addr = (cur_addr & ~(step - AW'(1))) + step;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            last_read <= 1'b0;
        end else if (pick_read || pick_write) begin
            active    <= 1'b1;
            last_read <= pick_read;
        end else if (beat_go && beat_last) begin
            active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pick_read || pick_write) begin
            cur_read   <= pick_read;
            cur_id     <= sel.id;
            cur_addr   <= sel.addr;
            cur_len    <= sel.len;
            beats_left <= sel.len;
            cur_shift  <= load_shift;
            cur_burst  <= sel.burst;
        end else if (beat_go) begin
            cur_addr   <= next_addr;
            beats_left <= beats_left - 4'd1;
        end
    end

endmodule

`default_nettype wire

// ==== source/beat_memory.sv ====
// Word memory with byte strobes, one-cycle read latency and an address range check
`timescale 1ns/1ns
`default_nettype none
`include "axi3_consts.svh"

module beat_memory (
    input  logic                          clk,
    input  logic                          mem_en,
    input  logic                          mem_write,
    input  logic [`AXI3_ADDR_WID-1:0]     mem_addr,
    input  logic [`AXI3_DATA_WID-1:0]     mem_wdata,
    input  logic [`AXI3_DATA_BYTES-1:0]   mem_strb,
    output logic [`AXI3_DATA_WID-1:0]     mem_rdata,
    output logic                          mem_err
);
    localparam int OFF_WID = $clog2(`AXI3_DATA_BYTES);
    localparam int IDX_WID = $clog2(`AXI3_MEM_WORDS);
    localparam int LIMIT = `AXI3_MEM_WORDS * `AXI3_DATA_BYTES;

    logic [`AXI3_DATA_WID-1:0] mem [`AXI3_MEM_WORDS];
    logic                      in_range;
    logic [IDX_WID-1:0]        idx;

    assign in_range = (int'(mem_addr) < LIMIT);
    assign idx = mem_addr[IDX_WID+OFF_WID-1:OFF_WID];

    always_ff @(posedge clk) begin
        if (mem_en && mem_write && in_range) begin
            for (int b = 0; b < `AXI3_DATA_BYTES; b++) begin
                if (mem_strb[b]) begin
                    mem[idx][b*8 +: 8] <= mem_wdata[b*8 +: 8];
                end
            end
        end
    end

    // Out of range reads back zero
    always_ff @(posedge clk) begin
        if (mem_en) begin
            mem_rdata <= in_range ? mem[idx] : '0;
            mem_err   <= !in_range;
        end
    end

endmodule

`default_nettype wire

// ==== source/response_builder.sv ====
// Builds B and R payloads from beat tags and memory results, stalling the decoder while one waits
`timescale 1ns/1ns
`default_nettype none
`include "axi3_consts.svh"

module response_builder (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          beat_valid,
    input  logic                          beat_is_read,
    input  logic [`AXI3_ID_WID-1:0]       beat_id,
    input  logic                          beat_last,
    input  logic [`AXI3_DATA_WID-1:0]     mem_rdata,
    input  logic                          mem_err,
    output logic                          stall,
    output logic                          b_valid,
    output axi3_pkg::b_payload_t          b_payload,
    input  logic                          b_ready,
    output logic                          r_valid,
    output axi3_pkg::r_payload_t          r_payload,
    input  logic                          r_ready
);
    import axi3_pkg::*;

    logic                    rd_beat;
    logic                    wr_beat;
    logic [`AXI3_ID_WID-1:0] r_id;
    logic                    r_last;
    logic [`AXI3_ID_WID-1:0] b_id;
    logic                    first_beat;
    logic                    err_acc;

    assign rd_beat = beat_valid && beat_is_read;
    assign wr_beat = beat_valid && !beat_is_read;

    // Memory output holds while stalled, so data is taken from it directly
    assign r_payload.id   = r_id;
    assign r_payload.data = mem_rdata;
    assign r_payload.resp = mem_err ? RESP_SLVERR : RESP_OKAY;
    assign r_payload.last = r_last;

    // Last beat error is still on mem_err while B waits
    assign b_payload.id   = b_id;
    assign b_payload.resp = (err_acc || mem_err) ? RESP_SLVERR : RESP_OKAY;

    assign stall = (r_valid && !r_ready) || (b_valid && !b_ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            r_valid    <= 1'b0;
            b_valid    <= 1'b0;
            first_beat <= 1'b1;
        end else begin
            if (rd_beat) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
            if (wr_beat && beat_last) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (wr_beat) begin
                first_beat <= beat_last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_beat) begin
            r_id   <= beat_id;
            r_last <= beat_last;
        end
        if (wr_beat) begin
            // Fold in the previous beat of the same burst
            err_acc <= !first_beat && (err_acc || mem_err);
        end
        if (wr_beat && beat_last) begin
            b_id <= beat_id;
        end
    end

endmodule

`default_nettype wire

// ==== source/axi3_mem_top.sv ====
// AXI3 subordinate memory top level, wiring the adapter, decoder, memory and response builder
`timescale 1ns/1ns
`default_nettype none
`include "axi3_consts.svh"

module axi3_mem_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          awvalid,
    input  logic [`AXI3_ID_WID-1:0]       awid,
    input  logic [`AXI3_ADDR_WID-1:0]     awaddr,
    input  logic [3:0]                    awlen,
    input  logic [2:0]                    awsize,
    input  logic [1:0]                    awburst,
    output logic                          awready,
    input  logic                          wvalid,
    input  logic [`AXI3_ID_WID-1:0]       wid,
    input  logic [`AXI3_DATA_WID-1:0]     wdata,
    input  logic [`AXI3_DATA_BYTES-1:0]   wstrb,
    input  logic                          wlast,
    output logic                          wready,
    output logic                          bvalid,
    output logic [`AXI3_ID_WID-1:0]       bid,
    output logic [1:0]                    bresp,
    input  logic                          bready,
    input  logic                          arvalid,
    input  logic [`AXI3_ID_WID-1:0]       arid,
    input  logic [`AXI3_ADDR_WID-1:0]     araddr,
    input  logic [3:0]                    arlen,
    input  logic [2:0]                    arsize,
    input  logic [1:0]                    arburst,
    output logic                          arready,
    output logic                          rvalid,
    output logic [`AXI3_ID_WID-1:0]       rid,
    output logic [`AXI3_DATA_WID-1:0]     rdata,
    output logic [1:0]                    rresp,
    output logic                          rlast,
    input  logic                          rready
);
    import axi3_pkg::*;

    logic                        aw_valid;
    ax_payload_t                 aw_payload;
    logic                        aw_ready;
    logic                        w_valid;
    w_payload_t                  w_payload;
    logic                        w_ready;
    logic                        ar_valid;
    ax_payload_t                 ar_payload;
    logic                        ar_ready;
    logic                        b_valid;
    b_payload_t                  b_payload;
    logic                        b_ready;
    logic                        r_valid;
    r_payload_t                  r_payload;
    logic                        r_ready;
    logic                        stall;
    logic                        mem_en;
    logic                        mem_write;
    logic [`AXI3_ADDR_WID-1:0]   mem_addr;
    logic [`AXI3_DATA_WID-1:0]   mem_wdata;
    logic [`AXI3_DATA_BYTES-1:0] mem_strb;
    logic [`AXI3_DATA_WID-1:0]   mem_rdata;
    logic                        mem_err;
    logic                        beat_is_read;
    logic [`AXI3_ID_WID-1:0]     beat_id;
    logic                        beat_last;

    axi3_bus_adapter u_adapter (
        .clk, .reset,
        .awvalid, .awid, .awaddr, .awlen, .awsize, .awburst, .awready,
        .wvalid, .wid, .wdata, .wstrb, .wlast, .wready,
        .bvalid, .bid, .bresp, .bready,
        .arvalid, .arid, .araddr, .arlen, .arsize, .arburst, .arready,
        .rvalid, .rid, .rdata, .rresp, .rlast, .rready,
        .aw_valid, .aw_payload, .aw_ready,
        .w_valid, .w_payload, .w_ready,
        .ar_valid, .ar_payload, .ar_ready,
        .b_valid, .b_payload, .b_ready,
        .r_valid, .r_payload, .r_ready
    );

    burst_decoder u_decoder (
        .clk, .reset,
        .aw_valid, .aw_payload, .aw_ready,
        .w_valid, .w_payload, .w_ready,
        .ar_valid, .ar_payload, .ar_ready,
        .stall,
        .mem_en, .mem_write, .mem_addr, .mem_wdata, .mem_strb,
        .beat_is_read, .beat_id, .beat_last
    );

    beat_memory u_memory (
        .clk,
        .mem_en, .mem_write, .mem_addr, .mem_wdata, .mem_strb,
        .mem_rdata, .mem_err
    );

    response_builder u_builder (
        .clk, .reset,
        .beat_valid (mem_en),
        .beat_is_read, .beat_id, .beat_last,
        .mem_rdata, .mem_err,
        .stall,
        .b_valid, .b_payload, .b_ready,
        .r_valid, .r_payload, .r_ready
    );

endmodule

`default_nettype wire

// ==== dv/axi3_mem_tb.sv ====
// Table-driven testbench for the AXI3 memory; compile with tb.f, axi3_mem_tb is the top module
`timescale 1ns/1ns
`default_nettype none
`include "axi3_consts.svh"

module axi3_mem_tb;
    import axi3_pkg::*;

    localparam int MEM_BYTES = `AXI3_MEM_WORDS * `AXI3_DATA_BYTES;

    typedef struct {
        logic                      is_read;
        logic [`AXI3_ID_WID-1:0]   id;
        logic [`AXI3_ADDR_WID-1:0] addr;
        logic [3:0]                len;
        axsize_t                   size;
        axburst_t                  burst;
        logic                      rand_strb;
        resp_t                     resp;
    } txn_t;

    logic                        clk;
    logic                        reset;
    logic                        awvalid;
    logic [`AXI3_ID_WID-1:0]     awid;
    logic [`AXI3_ADDR_WID-1:0]   awaddr;
    logic [3:0]                  awlen;
    logic [2:0]                  awsize;
    logic [1:0]                  awburst;
    logic                        awready;
    logic                        wvalid;
    logic [`AXI3_ID_WID-1:0]     wid;
    logic [`AXI3_DATA_WID-1:0]   wdata;
    logic [`AXI3_DATA_BYTES-1:0] wstrb;
    logic                        wlast;
    logic                        wready;
    logic                        bvalid;
    logic [`AXI3_ID_WID-1:0]     bid;
    logic [1:0]                  bresp;
    logic                        bready;
    logic                        arvalid;
    logic [`AXI3_ID_WID-1:0]     arid;
    logic [`AXI3_ADDR_WID-1:0]   araddr;
    logic [3:0]                  arlen;
    logic [2:0]                  arsize;
    logic [1:0]                  arburst;
    logic                        arready;
    logic                        rvalid;
    logic [`AXI3_ID_WID-1:0]     rid;
    logic [`AXI3_DATA_WID-1:0]   rdata;
    logic [1:0]                  rresp;
    logic                        rlast;
    logic                        rready;

    logic [`AXI3_DATA_WID-1:0] model [`AXI3_MEM_WORDS];
    logic [31:0]               lfsr = 32'h9985;
    txn_t                      txns[$];
    int                        exp_b = 0;
    int                        exp_r = 0;
    int                        total_beats = 0;
    int                        b_count = 0;
    int                        r_count = 0;
    int                        cycles = 0;
    int                        limit = 1000000;

    axi3_mem_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: transactions did not complete within %0d cycles", limit);
            end_with_failure();
        end
    end

    task automatic end_with_failure();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end_with_failure();
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [15:0] next_addr(input logic [15:0] a, input int shift,
                                              input axburst_t burst, input logic [3:0] len);
        int step;
        int block;
        int base;
        step = 1 << shift;
        block = (int'(len) + 1) * step;
        base = (int'(a) / block) * block;
        case (burst)
            BURST_FIXED: return a;
            BURST_WRAP:  return 16'(base + ((int'(a) - base + step) % block));
            default:     return 16'((int'(a) / step) * step + step);
        endcase
    endfunction

    // Byte lanes that a beat of this size may touch
    function automatic logic [3:0] lane_mask(input logic [15:0] a, input int shift);
        int n;
        int lo;
        n = 1 << shift;
        lo = (int'(a[1:0]) / n) * n;
        return 4'(((1 << n) - 1) << lo);
    endfunction

    task automatic model_write(input logic [15:0] a, input logic [31:0] d, input logic [3:0] s);
        if (int'(a) < MEM_BYTES) begin
            for (int b = 0; b < `AXI3_DATA_BYTES; b++) begin
                if (s[b]) begin
                    model[a[9:2]][b*8 +: 8] = d[b*8 +: 8];
                end
            end
        end
    endtask

    function automatic logic [31:0] model_read(input logic [15:0] a);
        return (int'(a) < MEM_BYTES) ? model[a[9:2]] : 32'h0;
    endfunction

    task automatic add_txn(input logic is_read, input logic [3:0] id, input logic [15:0] addr,
                           input logic [3:0] len, input axsize_t size, input axburst_t burst,
                           input logic rand_strb, input resp_t resp);
        txn_t t;
        t.is_read = is_read;
        t.id = id;
        t.addr = addr;
        t.len = len;
        t.size = size;
        t.burst = burst;
        t.rand_strb = rand_strb;
        t.resp = resp;
        txns.push_back(t);
        total_beats += int'(len) + 1;
        if (is_read) begin
            exp_r += int'(len) + 1;
        end else begin
            exp_b++;
        end
    endtask

    task automatic load_wbeat(input txn_t t, input logic [15:0] a, input int beat, input int shift);
        logic [31:0] r;
        wvalid = 1'b1;
        wid = t.id;
        wdata = rand_bits(32);
        r = rand_bits(4);
        wstrb = lane_mask(a, shift) & (t.rand_strb ? r[3:0] : 4'hf);
        wlast = (beat == int'(t.len));
    endtask

    // Runs one burst to completion; entered and left on a falling edge
    task automatic run_txn(input txn_t t);
        int          shift;
        int          beat;
        logic [15:0] addr;
        logic        a_fire;
        logic        w_fire;
        logic        b_fire;
        logic        r_fire;
        logic        done;
        shift = (int'(t.size) > 2) ? 2 : int'(t.size);
        addr = t.addr;
        beat = 0;
        done = 1'b0;
        if (t.is_read) begin
            arvalid = 1'b1;
            arid = t.id;
            araddr = t.addr;
            arlen = t.len;
            arsize = t.size;
            arburst = t.burst;
        end else begin
            awvalid = 1'b1;
            awid = t.id;
            awaddr = t.addr;
            awlen = t.len;
            awsize = t.size;
            awburst = t.burst;
            load_wbeat(t, addr, 0, shift);
        end
        while (!done) begin
            bready = |rand_bits(2);
            rready = |rand_bits(2);
            // Ready outputs depend on bready and rready through the stall path
            #1;
            a_fire = (awvalid && awready) || (arvalid && arready);
            w_fire = wvalid && wready;
            b_fire = bvalid && bready;
            r_fire = rvalid && rready;
            if (b_fire) begin
                b_count++;
                if (!t.is_read) begin
                    compare_value("bid", 32'(bid), 32'(t.id));
                    compare_value("bresp", 32'(bresp), 32'(t.resp));
                    done = 1'b1;
                end
            end
            if (r_fire) begin
                r_count++;
                if (t.is_read) begin
                    compare_value("rid", 32'(rid), 32'(t.id));
                    compare_value("rresp", 32'(rresp), 32'(t.resp));
                    compare_value("rdata", rdata, model_read(addr));
                    compare_value("rlast", 32'(rlast), 32'(beat == int'(t.len)));
                    addr = next_addr(addr, shift, t.burst, t.len);
                    beat++;
                    done = (beat > int'(t.len));
                end
            end
            if (w_fire) begin
                model_write(addr, wdata, wstrb);
                addr = next_addr(addr, shift, t.burst, t.len);
                beat++;
            end
            @(negedge clk);
            if (a_fire) begin
                awvalid = 1'b0;
                arvalid = 1'b0;
            end
            if (w_fire) begin
                if (beat > int'(t.len)) begin
                    wvalid = 1'b0;
                    wlast = 1'b0;
                end else begin
                    load_wbeat(t, addr, beat, shift);
                end
            end
        end
    endtask

    task automatic build_table();
        add_txn(1'b0, 4'd1, 16'h0040, 4'd7, SIZE_4B, BURST_INCR, 1'b0, RESP_OKAY);
        add_txn(1'b1, 4'd2, 16'h0040, 4'd7, SIZE_4B, BURST_INCR, 1'b0, RESP_OKAY);
        add_txn(1'b0, 4'd3, 16'h0100, 4'd3, SIZE_4B, BURST_INCR, 1'b0, RESP_OKAY);
        add_txn(1'b0, 4'd4, 16'h0100, 4'd3, SIZE_4B, BURST_INCR, 1'b1, RESP_OKAY);
        add_txn(1'b0, 4'd5, 16'h0102, 4'd1, SIZE_2B, BURST_INCR, 1'b0, RESP_OKAY);
        add_txn(1'b0, 4'd6, 16'h0109, 4'd2, SIZE_1B, BURST_INCR, 1'b0, RESP_OKAY);
        add_txn(1'b1, 4'd7, 16'h0100, 4'd3, SIZE_4B, BURST_INCR, 1'b0, RESP_OKAY);
        add_txn(1'b0, 4'd8, 16'h0200, 4'd3, SIZE_4B, BURST_INCR, 1'b0, RESP_OKAY);
        add_txn(1'b0, 4'd9, 16'h0208, 4'd3, SIZE_4B, BURST_WRAP, 1'b0, RESP_OKAY);
        add_txn(1'b1, 4'd10, 16'h0200, 4'd3, SIZE_4B, BURST_INCR, 1'b0, RESP_OKAY);
        add_txn(1'b0, 4'd11, 16'h0300, 4'd3, SIZE_4B, BURST_FIXED, 1'b0, RESP_OKAY);
        add_txn(1'b1, 4'd12, 16'h0300, 4'd0, SIZE_4B, BURST_INCR, 1'b0, RESP_OKAY);
        // Word 0 is where an unchecked write to 0x0800 would land
        add_txn(1'b0, 4'd13, 16'h0000, 4'd1, SIZE_4B, BURST_INCR, 1'b0, RESP_OKAY);
        add_txn(1'b0, 4'd14, 16'h0800, 4'd1, SIZE_4B, BURST_INCR, 1'b0, RESP_SLVERR);
        add_txn(1'b1, 4'd15, 16'h0000, 4'd1, SIZE_4B, BURST_INCR, 1'b0, RESP_OKAY);
        add_txn(1'b1, 4'd0, 16'h0800, 4'd1, SIZE_4B, BURST_INCR, 1'b0, RESP_SLVERR);
        add_txn(1'b1, 4'd1, 16'h0204, 4'd3, SIZE_4B, BURST_WRAP, 1'b0, RESP_OKAY);
    endtask

    initial begin
        reset = 1'b1;
        awvalid = 1'b0;
        awid = '0;
        awaddr = '0;
        awlen = '0;
        awsize = '0;
        awburst = '0;
        wvalid = 1'b0;
        wid = '0;
        wdata = '0;
        wstrb = '0;
        wlast = 1'b0;
        bready = 1'b0;
        arvalid = 1'b0;
        arid = '0;
        araddr = '0;
        arlen = '0;
        arsize = '0;
        arburst = '0;
        rready = 1'b0;
        build_table();
        limit = 40 * total_beats + 3;
        repeat (3) @(posedge clk);
        @(negedge clk);
        compare_value("awready", 32'(awready), 32'h0);
        compare_value("wready", 32'(wready), 32'h0);
        compare_value("arready", 32'(arready), 32'h0);
        compare_value("bvalid", 32'(bvalid), 32'h0);
        compare_value("rvalid", 32'(rvalid), 32'h0);
        reset = 1'b0;
        for (int i = 0; i < txns.size(); i++) begin
            run_txn(txns[i]);
        end
        // Any extra response would show up here
        repeat (10) begin
            bready = 1'b1;
            rready = 1'b1;
            if (bvalid) begin
                b_count++;
            end
            if (rvalid) begin
                r_count++;
            end
            @(negedge clk);
        end
        if (b_count == exp_b && r_count == exp_r) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            compare_value("B response count", 32'(b_count), 32'(exp_b));
            compare_value("R beat count", 32'(r_count), 32'(exp_r));
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+source
source/axi3_pkg.sv
source/axi3_bus_adapter.sv
source/burst_decoder.sv
source/beat_memory.sv
source/response_builder.sv
source/axi3_mem_top.sv
dv/axi3_mem_tb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := axi3_mem_tb
FILELIST := tb.f
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD    := obj_dir
LOG      := sim.log
PASS     := Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
